// File: rtl/lj_pkg.sv
//********************************************************************
// Lennard-Jones force tile shared definitions
// Fixed-point widths, coefficient table geometry and the enum types
// used by the scheduler and the write port
//********************************************************************

package lj_pkg;

	// Datapath widths
	localparam int COORD_WIDTH  = 16;	// Signed particle coordinate
	localparam int DIFF_WIDTH   = 17;	// Signed coordinate difference
	localparam int R2_WIDTH     = 36;	// Unsigned squared distance
	localparam int COEF_WIDTH   = 16;	// Coefficient, slope and base
	localparam int FORCE_WIDTH  = 32;	// Signed force component

	// Table geometry, bin index sits at r2[BIN_SHIFT +: BIN_WIDTH]
	localparam int BIN_WIDTH    = 4;
	localparam int BIN_NUM      = 16;
	localparam int BIN_SHIFT    = 20;
	localparam int OFFSET_WIDTH = 8;	// Interpolation fraction just below the bin

	// Coefficient times difference is scaled down by this many bits
	localparam int FORCE_FRAC   = 8;

	typedef enum logic [1:0]
	{
		idle,
		issue,
		drain
	} sched_state_t;

	// Target memory of the write port
	typedef enum logic
	{
		sel_ref,
		sel_neighbor
	} ram_sel_t;

endpackage

// File: rtl/position_ram.sv
//********************************************************************
// Particle position memory
// Three coordinate arrays with a synchronous write port and a read
// port that registers its data when rd_en is high
//********************************************************************

module position_ram
	import lj_pkg::*;
#(
	parameter int DEPTH = 8,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
)
(
	input  logic                          clk,
	input  logic                          wr_en,
	input  logic [ADDR_WIDTH-1:0]         wr_addr,
	input  logic signed [COORD_WIDTH-1:0] wr_x,
	input  logic signed [COORD_WIDTH-1:0] wr_y,
	input  logic signed [COORD_WIDTH-1:0] wr_z,
	input  logic                          rd_en,
	input  logic [ADDR_WIDTH-1:0]         rd_addr,
	output logic signed [COORD_WIDTH-1:0] rd_x,
	output logic signed [COORD_WIDTH-1:0] rd_y,
	output logic signed [COORD_WIDTH-1:0] rd_z
);

	logic signed [COORD_WIDTH-1:0] mem_x [DEPTH];
	logic signed [COORD_WIDTH-1:0] mem_y [DEPTH];
	logic signed [COORD_WIDTH-1:0] mem_z [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem_x[wr_addr] <= wr_x;
			mem_y[wr_addr] <= wr_y;
			mem_z[wr_addr] <= wr_z;
		end
		if (rd_en)	// Data shows up one cycle after the read
		begin
			rd_x <= mem_x[rd_addr];
			rd_y <= mem_y[rd_addr];
			rd_z <= mem_z[rd_addr];
		end
	end

endmodule

// File: rtl/pair_scheduler.sv
//********************************************************************
// Pair scheduler
// Walks every reference particle against every neighbor particle,
// one pair per cycle, and tags the final pair
//********************************************************************

module pair_scheduler
	import lj_pkg::*;
#(
	parameter int REF_NUM      = 4,
	parameter int NEIGHBOR_NUM = 6,
	localparam int REF_AW      = $clog2(REF_NUM),
	localparam int NB_AW       = $clog2(NEIGHBOR_NUM)
)
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              done,
	output logic [REF_AW-1:0] ref_addr,
	output logic [NB_AW-1:0]  neighbor_addr,
	output logic              rd_en,
	output logic              pair_valid,
	output logic              pair_last,
	output logic              busy
);

	sched_state_t state;
	logic         ref_last;	// Reference counter on its final entry
	logic         nb_last;	// Neighbor counter on its final entry
	logic         issue_last;

	assign ref_last   = (ref_addr == REF_AW'(REF_NUM - 1));
	assign nb_last    = (neighbor_addr == NB_AW'(NEIGHBOR_NUM - 1));

	// One read per cycle for as long as we sit in issue
	assign rd_en      = (state == issue);
	assign issue_last = rd_en && ref_last && nb_last;	// Read of the final pair
	assign busy       = (state != idle);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state         <= idle;
			ref_addr      <= '0;
			neighbor_addr <= '0;
			pair_valid    <= 1'b0;
			pair_last     <= 1'b0;
		end
		else
		begin
			// Line up with the memory read latency
			pair_valid <= rd_en;
			pair_last  <= issue_last;

			case (state)
				idle:
				begin
					if (start)
						state <= issue;	// Counters already sit at zero
				end
				issue:
				begin
					// Neighbor index runs fastest
					if (nb_last)
					begin
						neighbor_addr <= '0;
						if (ref_last)
						begin
							ref_addr <= '0;
							state    <= drain;
						end
						else
							ref_addr <= ref_addr + 1'b1;
					end
					else
						neighbor_addr <= neighbor_addr + 1'b1;
				end
				drain:
				begin
					if (done)	// Final result has left the force stage
						state <= idle;
				end
				default:
					state <= idle;
			endcase
		end
	end

endmodule

// File: rtl/r2_compute.sv
//********************************************************************
// Squared distance pipeline
// Stage 1 forms reference minus neighbor per axis, stage 2 the sum of
// squares; differences and the last tag travel alongside
//********************************************************************

module r2_compute
	import lj_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          in_valid,
	input  logic                          in_last,
	input  logic signed [COORD_WIDTH-1:0] ref_x,
	input  logic signed [COORD_WIDTH-1:0] ref_y,
	input  logic signed [COORD_WIDTH-1:0] ref_z,
	input  logic signed [COORD_WIDTH-1:0] nb_x,
	input  logic signed [COORD_WIDTH-1:0] nb_y,
	input  logic signed [COORD_WIDTH-1:0] nb_z,
	output logic signed [DIFF_WIDTH-1:0]  dx,
	output logic signed [DIFF_WIDTH-1:0]  dy,
	output logic signed [DIFF_WIDTH-1:0]  dz,
	output logic [R2_WIDTH-1:0]           r2,
	output logic                          r2_valid,
	output logic                          r2_last
);

	logic signed [DIFF_WIDTH-1:0]   d1_x, d1_y, d1_z;	// Stage 1 differences
	logic                           v1, l1;
	logic signed [2*DIFF_WIDTH-1:0] sq_x, sq_y, sq_z;

	// Squares are never negative, so the top bit stays clear
	assign sq_x = d1_x * d1_x;
	assign sq_y = d1_y * d1_y;
	assign sq_z = d1_z * d1_z;

	always_ff @(posedge clk)
	begin
		// Operands sign-extend to the 17-bit result width
		d1_x <= ref_x - nb_x;
		d1_y <= ref_y - nb_y;
		d1_z <= ref_z - nb_z;

		dx   <= d1_x;
		dy   <= d1_y;
		dz   <= d1_z;
		r2   <= R2_WIDTH'(sq_x) + R2_WIDTH'(sq_y) + R2_WIDTH'(sq_z);
	end

	// Valid and last shift chain
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1       <= 1'b0;
			l1       <= 1'b0;
			r2_valid <= 1'b0;
			r2_last  <= 1'b0;
		end
		else
		begin
			v1       <= in_valid;
			l1       <= in_valid & in_last;
			r2_valid <= v1;
			r2_last  <= l1;
		end
	end

endmodule

// File: rtl/lj_force_eval.sv
//********************************************************************
// Lennard-Jones force evaluation
// Cutoff and zero exclusion, binned coefficient lookup with first
// order interpolation, then per-axis scaling of the differences
//********************************************************************

module lj_force_eval
	import lj_pkg::*;
#(
	parameter logic [R2_WIDTH-1:0] CUTOFF_2 = 36'd16777216
)
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          r2_valid,
	input  logic                          r2_last,
	input  logic [R2_WIDTH-1:0]           r2,
	input  logic signed [DIFF_WIDTH-1:0]  dx,
	input  logic signed [DIFF_WIDTH-1:0]  dy,
	input  logic signed [DIFF_WIDTH-1:0]  dz,
	output logic                          force_valid,
	output logic signed [FORCE_WIDTH-1:0] force_x,
	output logic signed [FORCE_WIDTH-1:0] force_y,
	output logic signed [FORCE_WIDTH-1:0] force_z,
	output logic                          done
);

	// Table word holds slope in the upper half, base in the lower half
	logic [2*COEF_WIDTH-1:0] coef_table [BIN_NUM];

	logic [BIN_WIDTH-1:0]                  bin;
	logic [OFFSET_WIDTH-1:0]               offset;
	logic signed [COEF_WIDTH-1:0]          slope, base;
	logic signed [COEF_WIDTH+OFFSET_WIDTH:0] interp_prod;
	logic signed [COEF_WIDTH-1:0]          coef_next;
	logic                                  excl_next;

	// Stage 1 registers
	logic                          v1, l1, excl1;
	logic signed [COEF_WIDTH-1:0]  coef1;
	logic signed [DIFF_WIDTH-1:0]  dx1, dy1, dz1;

	initial
		$readmemh("rtl/lj_coef.hex", coef_table);

	// Coefficient times difference, back to the coordinate scale
	function automatic logic signed [FORCE_WIDTH-1:0] scale_axis(
		input logic signed [COEF_WIDTH-1:0] coef,
		input logic signed [DIFF_WIDTH-1:0] diff
	);
		logic signed [COEF_WIDTH+DIFF_WIDTH-1:0] prod;
		prod = coef * diff;
		return FORCE_WIDTH'(prod >>> FORCE_FRAC);
	endfunction

	assign bin    = r2[BIN_SHIFT +: BIN_WIDTH];
	assign offset = r2[BIN_SHIFT-OFFSET_WIDTH +: OFFSET_WIDTH];	// Fraction inside the bin
	assign slope  = coef_table[bin][2*COEF_WIDTH-1:COEF_WIDTH];
	assign base   = coef_table[bin][COEF_WIDTH-1:0];

	// Offset is unsigned, so give it a zero sign bit
	assign interp_prod = slope * $signed({1'b0, offset});
	assign coef_next   = base + COEF_WIDTH'(interp_prod >>> OFFSET_WIDTH);

	// Coincident pairs and pairs at or past the cutoff carry no force
	assign excl_next   = (r2 == '0) || (r2 >= CUTOFF_2);

	always_ff @(posedge clk)
	begin
		excl1 <= excl_next;
		coef1 <= coef_next;
		dx1   <= dx;
		dy1   <= dy;
		dz1   <= dz;

		force_x <= excl1 ? '0 : scale_axis(coef1, dx1);
		force_y <= excl1 ? '0 : scale_axis(coef1, dy1);
		force_z <= excl1 ? '0 : scale_axis(coef1, dz1);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1          <= 1'b0;
			l1          <= 1'b0;
			force_valid <= 1'b0;
			done        <= 1'b0;
		end
		else
		begin
			v1          <= r2_valid;
			l1          <= r2_valid & r2_last;
			force_valid <= v1;
			done        <= v1 & l1;	// Only with the final result
		end
	end

endmodule

// File: rtl/lj_pipeline.sv
//********************************************************************
// Lennard-Jones force tile top level
// Write port demux, the two position memories, the pair scheduler
// and the distance and force pipelines
//********************************************************************

module lj_pipeline
	import lj_pkg::*;
#(
	parameter int REF_NUM               = 4,
	parameter int NEIGHBOR_NUM          = 6,
	parameter logic [R2_WIDTH-1:0] CUTOFF_2 = 36'd16777216,
	localparam int REF_AW               = $clog2(REF_NUM),
	localparam int NB_AW                = $clog2(NEIGHBOR_NUM),
	localparam int WR_ADDR_WIDTH        = (REF_AW > NB_AW) ? REF_AW : NB_AW
)
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wr_en,
	input  ram_sel_t                      wr_sel,
	input  logic [WR_ADDR_WIDTH-1:0]      wr_addr,
	input  logic signed [COORD_WIDTH-1:0] wr_x,
	input  logic signed [COORD_WIDTH-1:0] wr_y,
	input  logic signed [COORD_WIDTH-1:0] wr_z,
	input  logic                          start,
	output logic                          busy,
	output logic                          force_valid,
	output logic signed [FORCE_WIDTH-1:0] force_x,
	output logic signed [FORCE_WIDTH-1:0] force_y,
	output logic signed [FORCE_WIDTH-1:0] force_z,
	output logic                          done
);

	logic                          wr_ok, ref_we, nb_we;
	logic [REF_AW-1:0]             ref_addr;
	logic [NB_AW-1:0]              neighbor_addr;
	logic                          rd_en, pair_valid, pair_last;
	logic signed [COORD_WIDTH-1:0] ref_x, ref_y, ref_z;
	logic signed [COORD_WIDTH-1:0] nb_x, nb_y, nb_z;
	logic signed [DIFF_WIDTH-1:0]  dx, dy, dz;
	logic [R2_WIDTH-1:0]           r2;
	logic                          r2_valid, r2_last;

	// Memories are frozen while a run is in progress
	assign wr_ok  = wr_en & ~busy;
	assign ref_we = wr_ok & (wr_sel == sel_ref);
	assign nb_we  = wr_ok & (wr_sel == sel_neighbor);

	position_ram #(.DEPTH(REF_NUM)) u_ref_ram
	(
		.clk(clk), .wr_en(ref_we), .wr_addr(wr_addr[REF_AW-1:0]),
		.wr_x(wr_x), .wr_y(wr_y), .wr_z(wr_z),
		.rd_en(rd_en), .rd_addr(ref_addr),
		.rd_x(ref_x), .rd_y(ref_y), .rd_z(ref_z)
	);

	position_ram #(.DEPTH(NEIGHBOR_NUM)) u_nb_ram
	(
		.clk(clk), .wr_en(nb_we), .wr_addr(wr_addr[NB_AW-1:0]),
		.wr_x(wr_x), .wr_y(wr_y), .wr_z(wr_z),
		.rd_en(rd_en), .rd_addr(neighbor_addr),
		.rd_x(nb_x), .rd_y(nb_y), .rd_z(nb_z)
	);

	pair_scheduler #(.REF_NUM(REF_NUM), .NEIGHBOR_NUM(NEIGHBOR_NUM)) u_sched
	(
		.clk(clk), .rst(rst), .start(start), .done(done),	// done closes the run
		.ref_addr(ref_addr), .neighbor_addr(neighbor_addr), .rd_en(rd_en),
		.pair_valid(pair_valid), .pair_last(pair_last), .busy(busy)
	);

	r2_compute u_r2
	(
		.clk(clk), .rst(rst), .in_valid(pair_valid), .in_last(pair_last),
		.ref_x(ref_x), .ref_y(ref_y), .ref_z(ref_z),
		.nb_x(nb_x), .nb_y(nb_y), .nb_z(nb_z),
		.dx(dx), .dy(dy), .dz(dz), .r2(r2),
		.r2_valid(r2_valid), .r2_last(r2_last)
	);

	lj_force_eval #(.CUTOFF_2(CUTOFF_2)) u_force
	(
		.clk(clk), .rst(rst), .r2_valid(r2_valid), .r2_last(r2_last),
		.r2(r2), .dx(dx), .dy(dy), .dz(dz),
		.force_valid(force_valid), .force_x(force_x), .force_y(force_y),
		.force_z(force_z), .done(done)
	);

endmodule

// File: test/lj_pipeline_checker.sv
//********************************************************************
// Lennard-Jones tile strobe checker
// Concurrent assertions on start, busy, force_valid and done, bound
// into the top level
//********************************************************************

module lj_pipeline_checker
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic force_valid,
	input logic done
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;	// Read by the testbench at the end of the run

	// done only ever rides on the final result
	done_with_result: assert property (@(posedge clk) disable iff (rst) done |-> force_valid)
		else begin fail_count++; $error("done seen without force_valid"); end

	result_while_busy: assert property (@(posedge clk) disable iff (rst) force_valid |-> busy)
		else begin fail_count++; $error("force_valid seen while not busy"); end

	// A start inside a run is ignored, the run carries on
	start_ignored: assert property (@(posedge clk) disable iff (rst)
		(start && busy && !done) |=> busy)
		else begin fail_count++; $error("start during a run dropped busy"); end

endmodule

bind lj_pipeline lj_pipeline_checker u_checker
(
	.clk(clk), .rst(rst), .start(start), .busy(busy),
	.force_valid(force_valid), .done(done)
);

// File: test/lj_pipeline_tb.sv
//********************************************************************
// Lennard-Jones force tile testbench
// Directed runs over loaded position memories, checked against a
// fixed-point model of the cutoff, table and scaling rules
//********************************************************************

module lj_pipeline_tb
	import lj_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int REF_NUM = 4;
	localparam int NB_NUM = 6;
	localparam logic [R2_WIDTH-1:0] CUTOFF_2 = 36'h100_0000;	// 2^24
	localparam int PAIR_NUM = REF_NUM * NB_NUM;
	localparam int RUN_NUM = 7;	// Runs over all tests
	localparam int TIMEOUT_CYCLES = 40 + 4 * PAIR_NUM * RUN_NUM;
	localparam int ADDR_W = $clog2(NB_NUM);	// Wider of the two memories
	localparam int FIRST_LATENCY = 5;	// First rd_en cycle to first result
	localparam logic [31:0] SEED = 32'h400e_5592;

	logic clk = 1'b0;
	logic rst;
	logic wr_en;
	ram_sel_t wr_sel;
	logic [ADDR_W-1:0] wr_addr;
	logic signed [COORD_WIDTH-1:0] wr_x, wr_y, wr_z;
	logic start;
	logic busy, force_valid, done;
	logic signed [FORCE_WIDTH-1:0] force_x, force_y, force_z;

	// Model state
	logic [2*COEF_WIDTH-1:0] model_table [BIN_NUM];
	logic signed [COORD_WIDTH-1:0] ref_pos [REF_NUM][3];
	logic signed [COORD_WIDTH-1:0] nb_pos [NB_NUM][3];
	logic signed [FORCE_WIDTH-1:0] exp_f [PAIR_NUM][3];
	logic signed [FORCE_WIDTH-1:0] got_f [PAIR_NUM][3];	// Last run as seen at the outputs
	string axis_tag [3] = '{"x", "y", "z"};
	int cycle_count = 0;

	lj_pipeline #(.REF_NUM(REF_NUM), .NEIGHBOR_NUM(NB_NUM), .CUTOFF_2(CUTOFF_2)) u_dut
	(
		.clk(clk), .rst(rst), .wr_en(wr_en), .wr_sel(wr_sel), .wr_addr(wr_addr),
		.wr_x(wr_x), .wr_y(wr_y), .wr_z(wr_z), .start(start), .busy(busy),
		.force_valid(force_valid), .force_x(force_x), .force_y(force_y),
		.force_z(force_z), .done(done)
	);

	always #4 clk = ~clk;	// 8 ns period

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_force(input string name, input logic signed [FORCE_WIDTH-1:0] got,
		input logic signed [FORCE_WIDTH-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic int rand_coord();
		// Small coordinates that stay mostly inside the cutoff
		return int'($urandom_range(2400)) - 1200;
	endfunction

	// One write through the port that is mirrored into the model
	task automatic write_pos(input ram_sel_t sel, input int addr, input int x, input int y,
		input int z);
		@(negedge clk);
		wr_en = 1'b1;
		wr_sel = sel;
		wr_addr = ADDR_W'(addr);
		wr_x = COORD_WIDTH'(x);
		wr_y = COORD_WIDTH'(y);
		wr_z = COORD_WIDTH'(z);
		if (sel == sel_ref)
			ref_pos[addr] = '{wr_x, wr_y, wr_z};
		else
			nb_pos[addr] = '{wr_x, wr_y, wr_z};
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic load_random();
		for (int i = 0; i < REF_NUM; i++)
			write_pos(sel_ref, i, rand_coord(), rand_coord(), rand_coord());
		for (int i = 0; i < NB_NUM; i++)
			write_pos(sel_neighbor, i, rand_coord(), rand_coord(), rand_coord());
	endtask

	// Expected forces for every pair in reference-major order
	task automatic build_expected();
		longint d [3];
		longint dist2, slope, base, offset, coef;
		int bin_idx, idx;
		logic signed [COEF_WIDTH-1:0] coef_w;
		for (int r = 0; r < REF_NUM; r++)
			for (int n = 0; n < NB_NUM; n++)
			begin
				idx = r * NB_NUM + n;
				dist2 = 0;
				for (int a = 0; a < 3; a++)
				begin
					// Reference minus neighbor
					d[a] = longint'(ref_pos[r][a]) - longint'(nb_pos[n][a]);
					dist2 += d[a] * d[a];
				end
				bin_idx = int'((dist2 >> BIN_SHIFT) % BIN_NUM);
				offset = (dist2 >> (BIN_SHIFT - OFFSET_WIDTH)) % (1 << OFFSET_WIDTH);
				slope = longint'($signed(model_table[bin_idx][2*COEF_WIDTH-1:COEF_WIDTH]));
				base = longint'($signed(model_table[bin_idx][COEF_WIDTH-1:0]));
				coef_w = COEF_WIDTH'(base + ((slope * offset) >>> OFFSET_WIDTH));	// 16-bit wrap
				coef = longint'(coef_w);
				for (int a = 0; a < 3; a++)
					if (dist2 == 0 || dist2 >= longint'(CUTOFF_2))
						exp_f[idx][a] = '0;	// Coincident or outside cutoff
					else
						exp_f[idx][a] = FORCE_WIDTH'((coef * d[a]) >>> FORCE_FRAC);
			end
	endtask

	// One full run where poke >= 0 adds a write and a start at that result
	task automatic run_and_check(input int poke);
		int k;
		int waited;
		build_expected();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_flag("busy", busy, 1'b1);
		k = 0;
		waited = 0;
		while (k < PAIR_NUM)
		begin
			@(negedge clk);
			wr_en = 1'b0;
			start = 1'b0;
			if (force_valid)
			begin
				if (k == 0 && waited != FIRST_LATENCY - 1)
					fail_run($sformatf("first result came %0d cycles after the first read",
						waited + 1));
				got_f[k] = '{force_x, force_y, force_z};
				for (int a = 0; a < 3; a++)
					check_force($sformatf("force_%s[%0d]", axis_tag[a], k), got_f[k][a],
						exp_f[k][a]);
				check_flag("done", done, logic'(k == PAIR_NUM - 1));	// Only on the final pair
				check_flag("busy", busy, 1'b1);
				if (k == poke)
				begin
					wr_en = 1'b1;	// Must be dropped while busy
					wr_sel = sel_ref;
					wr_addr = ADDR_W'(3);
					wr_x = 16'sd100;
					wr_y = -16'sd100;
					wr_z = 16'sd50;
					start = 1'b1;
				end
				k++;
			end
			else if (k > 0)
				fail_run("result stream stopped before the final pair");
			else
			begin
				waited++;
				if (waited >= FIRST_LATENCY)
					fail_run("no result arrived after start");
				check_flag("done", done, 1'b0);
			end
		end
		@(negedge clk);
		check_flag("force_valid", force_valid, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("busy", busy, 1'b0);	// Back to idle one edge after done
	endtask

	task automatic test_load_stream();
		load_random();
		run_and_check(-1);
	endtask

	task automatic test_cutoff();
		write_pos(sel_ref, 0, 0, 0, 0);
		for (int i = 1; i < REF_NUM; i++)
			write_pos(sel_ref, i, rand_coord(), rand_coord(), rand_coord());
		write_pos(sel_neighbor, 0, 0, 0, 0);	// Coincident with ref 0
		write_pos(sel_neighbor, 1, 4096, 0, 0);	// r2 exactly at cutoff
		write_pos(sel_neighbor, 2, 4095, 0, 0);	// Just inside
		write_pos(sel_neighbor, 3, 3000, 3000, 0);
		write_pos(sel_neighbor, 4, 0, -4095, 0);
		write_pos(sel_neighbor, 5, 0, 0, -4097);
		run_and_check(-1);
		for (int a = 0; a < 3; a++)
		begin
			check_force($sformatf("force_%s[0]", axis_tag[a]), got_f[0][a], '0);
			check_force($sformatf("force_%s[1]", axis_tag[a]), got_f[1][a], '0);
		end
		if (got_f[2][0] == '0)
			fail_run("pair just inside the cutoff gave no force");
	endtask

	// r2 lands at start, middle and end of bins 1 to 13
	task automatic test_bins();
		write_pos(sel_ref, 0, 0, 0, 0);	// Bins 1 and 4
		write_pos(sel_ref, 1, 0, 0, 3072);	// Bins 10 and 13
		write_pos(sel_ref, 2, 0, 0, -2048);	// Bins 5 and 8
		write_pos(sel_ref, 3, 0, 0, 1024);	// Bins 2 and 5
		write_pos(sel_neighbor, 0, 1024, 0, 0);
		write_pos(sel_neighbor, 1, 1024, 724, 0);	// Near mid bin
		write_pos(sel_neighbor, 2, 1024, 1023, 0);	// Offset 255
		write_pos(sel_neighbor, 3, 2048, 0, 0);
		write_pos(sel_neighbor, 4, 2048, 724, 0);
		write_pos(sel_neighbor, 5, 2048, 1023, 0);
		run_and_check(-1);
	endtask

	// Both runs are held to the same model values
	task automatic test_done_busy();
		run_and_check(-1);
		run_and_check(-1);
	endtask

	task automatic test_write_while_busy();
		load_random();
		run_and_check(3);	// Model keeps the old ref 3
		run_and_check(-1);
	endtask

	initial
	begin
		void'($urandom(SEED));
		$readmemh("rtl/lj_coef.hex", model_table);
		rst = 1'b1;
		start = 1'b0;
		wr_en = 1'b0;
		wr_sel = sel_ref;
		wr_addr = '0;
		wr_x = '0;
		wr_y = '0;
		wr_z = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_load_stream();
		test_cutoff();
		test_bins();
		test_done_busy();
		test_write_while_busy();

		@(negedge clk);
		if (u_dut.u_checker.fail_count == 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
		begin
			$display("Test FAILED");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule

// File: rtl/lj_coef.hex
// One word per bin, bins 0 to 15 in order
// Upper 16 bits signed slope, lower 16 bits signed base
F0007000
F4006000
F8005000
FA004400
FC003800
FD003000
FE002800
FE802000
FF001800
FF401000
FF800A00
FFA00400
FFC00000
FFE0FE00
0000FF00
0010FF80

// File: tb.f
rtl/lj_pkg.sv
rtl/position_ram.sv
rtl/pair_scheduler.sv
rtl/r2_compute.sv
rtl/lj_force_eval.sv
rtl/lj_pipeline.sv
test/lj_pipeline_checker.sv
test/lj_pipeline_tb.sv

// File: Bender.yml
package:
  name: lj_pipeline

sources:
  - files:
      - rtl/lj_pkg.sv
      - rtl/position_ram.sv
      - rtl/pair_scheduler.sv
      - rtl/r2_compute.sv
      - rtl/lj_force_eval.sv
      - rtl/lj_pipeline.sv
  - target: test
    files:
      - test/lj_pipeline_checker.sv
      - test/lj_pipeline_tb.sv
